// File: hw/axis_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer
  import out_writer_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  output logic  in_ready,
  input  data_t in_data,
  input  keep_t in_keep,
  input  logic  in_last,
  output logic  out_valid,
  input  logic  out_ready,
  output data_t out_data,
  output keep_t out_keep,
  output logic  out_last
);

  // Skid entry catches the beat taken while in_ready was still high
  logic  skid_valid;
  data_t skid_data;
  keep_t skid_keep;
  logic  skid_last;

  logic in_fire;
  logic main_load;

  assign in_fire = in_valid && in_ready;
  // Main register is free or drains this cycle
  assign main_load = !out_valid || out_ready;

  // Control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (main_load) begin
        out_valid  <= skid_valid || in_fire;
        skid_valid <= 1'b0;
        in_ready   <= 1'b1;
      end else if (in_fire) begin
        // Output stalled, park the beat and close the input
        skid_valid <= 1'b1;
        in_ready   <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        out_data <= skid_data;
        out_keep <= skid_keep;
        out_last <= skid_last;
      end else if (in_fire) begin
        out_data <= in_data;
        out_keep <= in_keep;
        out_last <= in_last;
      end
    end else if (in_fire) begin
      skid_data <= in_data;
      skid_keep <= in_keep;
      skid_last <= in_last;
    end
  end

endmodule

`default_nettype wire

// File: hw/meta_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module meta_arbiter #(
  parameter int N = 2,
  parameter int W = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [N-1:0]        in_valid,
  output logic [N-1:0]        in_ready,
  input  logic [N-1:0][W-1:0] in_payload,
  output logic                out_valid,
  input  logic                out_ready,
  output logic [W-1:0]        out_payload
);

  localparam int PTR_BITS = (N > 1) ? $clog2(N) : 1;

  // Index of the input granted last
  logic [PTR_BITS-1:0] last_grant;

  logic [PTR_BITS-1:0] grant_idx;
  logic                grant_found;
  logic                load;

  // Output slot is empty or drains this cycle
  assign load = !out_valid || out_ready;

  // Search starts one past the last grant and wraps around
  always_comb begin
    int idx;
    grant_idx   = '0;
    grant_found = 1'b0;
    for (int i = 1; i <= N; i++) begin
      idx = (int'(last_grant) + i) % N;
      if (!grant_found && in_valid[idx]) begin
        grant_found = 1'b1;
        grant_idx   = PTR_BITS'(idx);
      end
    end
  end

  // Only the granted input is taken
  always_comb begin
    in_ready = '0;
    if (load && grant_found) begin
      in_ready[grant_idx] = 1'b1;
    end
  end

  // Output valid and pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      last_grant <= PTR_BITS'(N - 1);
    end else if (load) begin
      out_valid <= grant_found;
      if (grant_found) begin
        last_grant <= grant_idx;
      end
    end
  end

  // Payload slot
  always_ff @(posedge clk) begin
    if (load && grant_found) begin
      out_payload <= in_payload[grant_idx];
    end
  end

endmodule

`default_nettype wire

// File: hw/out_writer_pkg.sv
`default_nettype none

package out_writer_pkg;

  // Stream count and data path
  localparam int N_STRM = 2;
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = DATA_BITS / 8;
  localparam int BEAT_BYTES = KEEP_BITS;

  // Chunking and completion limits
  localparam int TRANSFER_BYTES = 256;
  localparam int MAX_OUTSTANDING = 4;

  // Host request fields
  localparam int VADDR_BITS = 48;
  localparam int LEN_BITS = 28;
  localparam int STRM_BITS = 1;
  localparam int REQ_BITS = VADDR_BITS + LEN_BITS + STRM_BITS + 1;
  localparam int NOTIFY_BITS = STRM_BITS + LEN_BITS;

  // Counter widths
  localparam int OUTST_BITS = 3;
  // Holds 0..TRANSFER_BYTES inclusive
  localparam int CHUNK_BITS = $clog2(TRANSFER_BYTES) + 1;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [KEEP_BITS-1:0] keep_t;
  typedef logic [VADDR_BITS-1:0] vaddr_t;
  typedef logic [LEN_BITS-1:0] len_t;
  typedef logic [STRM_BITS-1:0] strm_id_t;

  // {vaddr, len, strm, last} from the top bit down
  typedef logic [REQ_BITS-1:0] req_t;

  // {strm, total bytes}
  typedef logic [NOTIFY_BITS-1:0] notify_t;

  // Stream writer FSM
  typedef enum logic [1:0] {
    SW_DATA,
    SW_REQ,
    SW_NOTIFY
  } sw_state_t;

endpackage

`default_nettype wire

// File: hw/output_writer.sv
`timescale 1ns/1ps
`default_nettype none

module output_writer
  import out_writer_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Per-stream buffer setup
  input  logic    [N_STRM-1:0]  cfg_valid,
  input  vaddr_t  [N_STRM-1:0]  cfg_vaddr,

  // Stream inputs
  input  logic    [N_STRM-1:0]  in_valid,
  output logic    [N_STRM-1:0]  in_ready,
  input  data_t   [N_STRM-1:0]  in_data,
  input  keep_t   [N_STRM-1:0]  in_keep,
  input  logic    [N_STRM-1:0]  in_last,

  // Host data ports
  output logic    [N_STRM-1:0]  out_valid,
  input  logic    [N_STRM-1:0]  out_ready,
  output data_t   [N_STRM-1:0]  out_data,
  output keep_t   [N_STRM-1:0]  out_keep,
  output logic    [N_STRM-1:0]  out_last,

  // Write request queue
  output logic                  sq_valid,
  input  logic                  sq_ready,
  output req_t                  sq_req,

  // Completion strobe
  input  logic                  cq_valid,
  input  strm_id_t              cq_strm,

  // Host notification
  output logic                  notify_valid,
  input  logic                  notify_ready,
  output notify_t               notify
);

  // Skid buffer to stream writer
  logic  [N_STRM-1:0] skid_valid;
  logic  [N_STRM-1:0] skid_ready;
  data_t [N_STRM-1:0] skid_data;
  keep_t [N_STRM-1:0] skid_keep;
  logic  [N_STRM-1:0] skid_last;

  // Stream writers to the arbiters
  logic    [N_STRM-1:0] req_valid;
  logic    [N_STRM-1:0] req_ready;
  req_t    [N_STRM-1:0] req_bus;
  logic    [N_STRM-1:0] ntf_valid;
  logic    [N_STRM-1:0] ntf_ready;
  notify_t [N_STRM-1:0] ntf_bus;

  for (genvar s = 0; s < N_STRM; s++) begin : g_strm
    // Registers the input and cuts the ready path
    axis_skid_buffer u_skid (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[s]),
      .in_ready  (in_ready[s]),
      .in_data   (in_data[s]),
      .in_keep   (in_keep[s]),
      .in_last   (in_last[s]),
      .out_valid (skid_valid[s]),
      .out_ready (skid_ready[s]),
      .out_data  (skid_data[s]),
      .out_keep  (skid_keep[s]),
      .out_last  (skid_last[s])
    );

    stream_writer #(
      .STRM_ID (s)
    ) u_writer (
      .clk          (clk),
      .rst_n        (rst_n),
      .cfg_valid    (cfg_valid[s]),
      .cfg_vaddr    (cfg_vaddr[s]),
      .in_valid     (skid_valid[s]),
      .in_ready     (skid_ready[s]),
      .in_data      (skid_data[s]),
      .in_keep      (skid_keep[s]),
      .in_last      (skid_last[s]),
      .out_valid    (out_valid[s]),
      .out_ready    (out_ready[s]),
      .out_data     (out_data[s]),
      .out_keep     (out_keep[s]),
      .out_last     (out_last[s]),
      .req_valid    (req_valid[s]),
      .req_ready    (req_ready[s]),
      .req          (req_bus[s]),
      .cq_valid     (cq_valid),
      .cq_strm      (cq_strm),
      .notify_valid (ntf_valid[s]),
      .notify_ready (ntf_ready[s]),
      .notify       (ntf_bus[s])
    );
  end

  // Merge write requests onto the shared queue
  meta_arbiter #(
    .N (N_STRM),
    .W (REQ_BITS)
  ) u_sq_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (req_valid),
    .in_ready    (req_ready),
    .in_payload  (req_bus),
    .out_valid   (sq_valid),
    .out_ready   (sq_ready),
    .out_payload (sq_req)
  );

  // Merge notifications
  meta_arbiter #(
    .N (N_STRM),
    .W (NOTIFY_BITS)
  ) u_notify_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (ntf_valid),
    .in_ready    (ntf_ready),
    .in_payload  (ntf_bus),
    .out_valid   (notify_valid),
    .out_ready   (notify_ready),
    .out_payload (notify)
  );

endmodule

`default_nettype wire

// File: hw/stream_writer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_writer
  import out_writer_pkg::*;
#(
  parameter int STRM_ID = 0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cfg_valid,
  input  vaddr_t   cfg_vaddr,
  input  logic     in_valid,
  output logic     in_ready,
  input  data_t    in_data,
  input  keep_t    in_keep,
  input  logic     in_last,
  output logic     out_valid,
  input  logic     out_ready,
  output data_t    out_data,
  output keep_t    out_keep,
  output logic     out_last,
  output logic     req_valid,
  input  logic     req_ready,
  output req_t     req,
  input  logic     cq_valid,
  input  strm_id_t cq_strm,
  output logic     notify_valid,
  input  logic     notify_ready,
  output notify_t  notify
);

  sw_state_t state;

  // Buffer base and running offset into it
  vaddr_t base;
  vaddr_t offset;

  // Bytes in the chunk being sent, and over the whole stream
  logic [CHUNK_BITS-1:0] chunk_bytes;
  len_t                  total_bytes;

  // Length and last flag of the chunk awaiting its request
  logic [CHUNK_BITS-1:0] chunk_len;
  logic                  last_chunk;

  // Requests issued but not yet completed
  logic [OUTST_BITS-1:0] outst;

  logic [CHUNK_BITS-1:0] beat_bytes;
  logic [CHUNK_BITS-1:0] chunk_next;
  logic                  chunk_end;
  logic                  at_limit;
  logic                  pass_en;
  logic                  beat_fire;
  logic                  req_fire;
  logic                  notify_fire;
  logic                  cq_hit;

  // Byte count of this beat from keep
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < KEEP_BITS; i++) begin
      beat_bytes = beat_bytes + CHUNK_BITS'(in_keep[i]);
    end
  end

  assign chunk_next = chunk_bytes + beat_bytes;
  // Chunk closes on a full transfer or on end of stream
  assign chunk_end  = (chunk_next >= CHUNK_BITS'(TRANSFER_BYTES)) || in_last;
  assign at_limit   = (outst == OUTST_BITS'(MAX_OUTSTANDING));
  assign pass_en    = (state == SW_DATA) && !at_limit;

  // Data path passes straight through while in SW_DATA
  assign out_valid = in_valid && pass_en;
  assign in_ready  = out_ready && pass_en;
  assign out_data  = in_data;
  assign out_keep  = in_keep;
  assign out_last  = chunk_end;

  assign beat_fire = in_valid && in_ready;

  // Request for the chunk just sent
  assign req_valid = (state == SW_REQ);
  assign req       = {base + offset, LEN_BITS'(chunk_len), strm_id_t'(STRM_ID), last_chunk};
  assign req_fire  = req_valid && req_ready;

  // Notify waits until every chunk of the stream is acknowledged
  assign notify_valid = (state == SW_NOTIFY) && (outst == '0);
  assign notify       = {strm_id_t'(STRM_ID), total_bytes};
  assign notify_fire  = notify_valid && notify_ready;

  // Only completions tagged with this stream count
  assign cq_hit = cq_valid && (cq_strm == strm_id_t'(STRM_ID));

  // FSM and byte counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= SW_DATA;
      chunk_bytes <= '0;
      total_bytes <= '0;
      last_chunk  <= 1'b0;
    end else begin
      case (state)
        SW_DATA: begin
          if (beat_fire) begin
            total_bytes <= total_bytes + LEN_BITS'(beat_bytes);
            if (chunk_end) begin
              chunk_bytes <= '0;
              last_chunk  <= in_last;
              state       <= SW_REQ;
            end else begin
              chunk_bytes <= chunk_next;
            end
          end
        end
        SW_REQ: begin
          if (req_fire) begin
            state <= last_chunk ? SW_NOTIFY : SW_DATA;
          end
        end
        SW_NOTIFY: begin
          if (notify_fire) begin
            total_bytes <= '0;
            state       <= SW_DATA;
          end
        end
        default: begin
          state <= SW_DATA;
        end
      endcase
    end
  end

  // Chunk length captured on the closing beat
  always_ff @(posedge clk) begin
    if (beat_fire && chunk_end) begin
      chunk_len <= chunk_next;
    end
  end

  // Address state, cfg reloads the base and restarts the offset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base   <= '0;
      offset <= '0;
    end else if (cfg_valid) begin
      base   <= cfg_vaddr;
      offset <= '0;
    end else if (req_fire) begin
      offset <= offset + VADDR_BITS'(chunk_len);
    end
  end

  // Outstanding counter, issue and completion may coincide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst <= '0;
    end else begin
      case ({req_fire, cq_hit})
        2'b10:   outst <= outst + 1'b1;
        2'b01:   outst <= outst - 1'b1;
        default: outst <= outst;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tb.f
hw/out_writer_pkg.sv
hw/axis_skid_buffer.sv
hw/stream_writer.sv
hw/meta_arbiter.sv
hw/output_writer.sv
testbench/tb_output_writer.sv

// File: testbench/tb_output_writer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_output_writer
  import out_writer_pkg::*;
();

  // One beat as it travels in and out of the DUT
  typedef struct packed {
    logic  last;
    keep_t keep;
    data_t data;
  } beat_t;

  logic                 clk;
  logic                 rst_n;
  logic   [N_STRM-1:0]  cfg_valid;
  vaddr_t [N_STRM-1:0]  cfg_vaddr;
  logic   [N_STRM-1:0]  in_valid;
  logic   [N_STRM-1:0]  in_ready;
  data_t  [N_STRM-1:0]  in_data;
  keep_t  [N_STRM-1:0]  in_keep;
  logic   [N_STRM-1:0]  in_last;
  logic   [N_STRM-1:0]  out_valid;
  logic   [N_STRM-1:0]  out_ready;
  data_t  [N_STRM-1:0]  out_data;
  keep_t  [N_STRM-1:0]  out_keep;
  logic   [N_STRM-1:0]  out_last;
  logic                 sq_valid;
  logic                 sq_ready;
  req_t                 sq_req;
  logic                 cq_valid;
  strm_id_t             cq_strm;
  logic                 notify_valid;
  logic                 notify_ready;
  notify_t              notify;

  // Source beats, expected results and pending completions
  beat_t    src_q[N_STRM][$];
  beat_t    exp_beat_q[N_STRM][$];
  req_t     exp_req_q[N_STRM][$];
  notify_t  exp_ntf_q[N_STRM][$];
  strm_id_t cq_q[$];

  // Reference address state per stream
  vaddr_t ref_base[N_STRM];
  vaddr_t ref_off[N_STRM];

  int          beat_cnt[N_STRM];
  int          req_cnt[N_STRM];
  int          mism_cnt = 0;
  int          other_cnt = 0;
  int          cycles = 0;
  int          cycle_limit = 2000;
  logic        stall_en = 1'b0;
  logic        cq_hold = 1'b0;
  logic [31:0] rand_state = 32'hf74b_87dd;

  output_writer UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check_data(input int s, input data_t got_d, input keep_t got_k,
                            input logic got_l, input beat_t exp);
    if (got_d !== exp.data || got_k !== exp.keep || got_l !== exp.last) begin
      mism_cnt++;
      $display("MISMATCH out_data/keep/last[%0d]: got %h/%h/%h expected %h/%h/%h",
               s, got_d, got_k, got_l, exp.data, exp.keep, exp.last);
    end
  endtask

  task automatic check_req(input req_t got, input req_t exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("MISMATCH sq_req: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_notify(input notify_t got, input notify_t exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("MISMATCH notify: got %h expected %h", got, exp);
    end
  endtask

  // Reference model that cuts a packet into chunks and queues what the host should see
  task automatic queue_packet(input int s, input int n_full, input int last_bytes);
    beat_t b;
    int    chunk;
    int    total;
    int    bytes;
    chunk = 0;
    total = 0;
    for (int i = 0; i <= n_full; i++) begin
      bytes  = (i == n_full) ? last_bytes : BEAT_BYTES;
      b.data = {next_rand(), next_rand()};
      b.keep = keep_t'((1 << bytes) - 1);
      b.last = (i == n_full);
      src_q[s].push_back(b);
      chunk += bytes;
      total += bytes;
      // Chunk closes at the transfer size or on the stream's last beat
      b.last = (chunk >= TRANSFER_BYTES) || (i == n_full);
      exp_beat_q[s].push_back(b);
      cycle_limit += 4;
      if (b.last) begin
        exp_req_q[s].push_back({ref_base[s] + ref_off[s], len_t'(chunk),
                                strm_id_t'(s), logic'(i == n_full)});
        ref_off[s] += vaddr_t'(chunk);
        chunk = 0;
        cycle_limit += 4;
      end
    end
    exp_ntf_q[s].push_back({strm_id_t'(s), len_t'(total)});
  endtask

  task automatic configure(input int s, input vaddr_t va);
    @(posedge clk);
    #2;
    cfg_valid[s] = 1'b1;
    cfg_vaddr[s] = va;
    @(posedge clk);
    #2;
    cfg_valid[s] = 1'b0;
    ref_base[s]  = va;
    ref_off[s]   = '0;
  endtask

  // Done once every queued beat, request, completion and notify has gone through
  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      #1;
      busy = (cq_q.size() != 0);
      for (int s = 0; s < N_STRM; s++) begin
        busy |= (src_q[s].size() != 0) || (exp_beat_q[s].size() != 0) ||
                (exp_req_q[s].size() != 0) || (exp_ntf_q[s].size() != 0);
      end
    end
    repeat (4) @(posedge clk);
  endtask

  // Inputs change 2 ns after the edge
  always @(posedge clk) begin
    logic [N_STRM-1:0] fired;
    logic [31:0]       r;
    beat_t             drop;
    fired = in_valid & in_ready;
    #2;
    for (int s = 0; s < N_STRM; s++) begin
      if (fired[s]) begin
        drop = src_q[s].pop_front();
      end
      in_valid[s] = (src_q[s].size() != 0);
      if (src_q[s].size() != 0) begin
        in_data[s] = src_q[s][0].data;
        in_keep[s] = src_q[s][0].keep;
        in_last[s] = src_q[s][0].last;
      end
      r = next_rand();
      out_ready[s] = !stall_en || (r[1:0] != 2'b00);
    end
    r = next_rand();
    sq_ready     = !stall_en || (r[3:2] != 2'b00);
    notify_ready = !stall_en || (r[5:4] != 2'b00);
    // One completion per cycle for each request seen on sq
    if (!cq_hold && cq_q.size() != 0) begin
      cq_valid = 1'b1;
      cq_strm  = cq_q.pop_front();
    end else begin
      cq_valid = 1'b0;
    end
  end

  // Output monitor sampling handshakes at the rising edge
  always @(posedge clk) begin
    int sid;
    if (rst_n) begin
      for (int s = 0; s < N_STRM; s++) begin
        if (out_valid[s] && out_ready[s]) begin
          beat_cnt[s]++;
          if (exp_beat_q[s].size() == 0) begin
            other_cnt++;
            $display("Extra data beat on stream %0d", s);
          end else begin
            check_data(s, out_data[s], out_keep[s], out_last[s], exp_beat_q[s].pop_front());
          end
        end
      end
      if (sq_valid && sq_ready) begin
        // Stream id sits just above the last flag
        sid = int'(sq_req[1]);
        req_cnt[sid]++;
        cq_q.push_back(sq_req[1]);
        if (exp_req_q[sid].size() == 0) begin
          other_cnt++;
          $display("Extra write request for stream %0d", sid);
        end else begin
          check_req(sq_req, exp_req_q[sid].pop_front());
        end
      end
      if (notify_valid && notify_ready) begin
        sid = int'(notify[LEN_BITS]);
        if (exp_ntf_q[sid].size() == 0) begin
          other_cnt++;
          $display("Extra notification for stream %0d", sid);
        end else begin
          check_notify(notify, exp_ntf_q[sid].pop_front());
        end
      end
    end
  end

  // Watchdog whose limit grows with every queued beat and request
  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, beats left %0d/%0d, requests left %0d/%0d",
             cycles, exp_beat_q[0].size(), exp_beat_q[1].size(),
             exp_req_q[0].size(), exp_req_q[1].size());
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic reset_and_full_chunks();
    if (out_valid !== '0 || sq_valid !== 1'b0 || notify_valid !== 1'b0) begin
      mism_cnt++;
      $display("MISMATCH valids after reset: out_valid %h sq_valid %h notify_valid %h",
               out_valid, sq_valid, notify_valid);
    end
    configure(0, 48'h0000_1234_5000);
    // 651 bytes in chunks of 256, 256 and 139
    queue_packet(0, 81, 3);
    wait_idle();
  endtask

  task automatic notify_and_restart();
    cq_hold = 1'b1;
    // Without a cfg strobe the addressing carries on after the previous stream
    queue_packet(0, 40, 8);
    while (exp_req_q[0].size() != 0) begin
      @(posedge clk);
    end
    // Notify has to wait for the held completions
    repeat (20) @(posedge clk);
    if (exp_ntf_q[0].size() == 0) begin
      other_cnt++;
      $display("Stream 0 notified before its completions arrived");
    end
    cq_hold = 1'b0;
    wait_idle();
  endtask

  task automatic concurrent_streams();
    configure(0, 48'h0000_8000_0000);
    configure(1, 48'h0000_9000_0100);
    queue_packet(0, 70, 5);
    queue_packet(1, 50, 2);
    queue_packet(0, 10, 1);
    queue_packet(1, 33, 7);
    wait_idle();
  endtask

  task automatic random_backpressure();
    stall_en = 1'b1;
    for (int k = 0; k < 3; k++) begin
      queue_packet(0, 20 + int'(next_rand() % 60), 1 + int'(next_rand() % 8));
      queue_packet(1, 20 + int'(next_rand() % 60), 1 + int'(next_rand() % 8));
    end
    wait_idle();
    stall_en = 1'b0;
  endtask

  task automatic outstanding_limit();
    int req_base;
    int beat_base;
    cq_hold   = 1'b1;
    req_base  = req_cnt[1];
    beat_base = beat_cnt[1];
    queue_packet(1, 192, 5);
    while (req_cnt[1] - req_base < MAX_OUTSTANDING) begin
      @(posedge clk);
    end
    // Stream must stay parked while the acks are held
    repeat (100) @(posedge clk);
    if (req_cnt[1] - req_base != MAX_OUTSTANDING) begin
      other_cnt++;
      $display("Stream 1 issued %0d requests with acks held", req_cnt[1] - req_base);
    end
    if (beat_cnt[1] - beat_base != MAX_OUTSTANDING * 32) begin
      other_cnt++;
      $display("Stream 1 kept sending data at the outstanding limit");
    end
    cq_hold = 1'b0;
    wait_idle();
  endtask

  task automatic reconfigure_base();
    configure(1, 48'h0000_00ab_c000);
    queue_packet(1, 35, 4);
    wait_idle();
  endtask

  initial begin
    rst_n        = 1'b0;
    cfg_valid    = '0;
    cfg_vaddr    = '0;
    in_valid     = '0;
    in_data      = '0;
    in_keep      = '0;
    in_last      = '0;
    out_ready    = '1;
    sq_ready     = 1'b1;
    cq_valid     = 1'b0;
    cq_strm      = '0;
    notify_ready = 1'b1;
    for (int s = 0; s < N_STRM; s++) begin
      ref_base[s] = '0;
      ref_off[s]  = '0;
      beat_cnt[s] = 0;
      req_cnt[s]  = 0;
    end
    repeat (5) @(posedge clk);
    if (in_ready !== '0) begin
      mism_cnt++;
      $display("MISMATCH in_ready during reset: got %h expected 0", in_ready);
    end
    #2;
    rst_n = 1'b1;
    reset_and_full_chunks();
    notify_and_restart();
    concurrent_streams();
    random_backpressure();
    outstanding_limit();
    reconfigure_base();
    $display("Errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
    if (mism_cnt + other_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
